/* Bender.yml */
package:
  name: acc_cpu_2port

sources:
  - include_dirs:
      - design
    files:
      - design/ahb_pkg.sv
      - design/acc_core_pkg.sv
      - design/acc_core.sv
      - design/ahb_lite_master_port.sv
      - design/acc_cpu_2port.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/ahb_mem_model.sv
      - tb/tb_acc_cpu_2port.sv

/* design/acc_core.sv */
// ----------------------------------------------------------
// Accumulator core, one fetch and at most one data transfer
// per instruction, split over instruction and data channels
// ----------------------------------------------------------

`timescale 1ns/100ps
`include "acc_defines.svh"

module acc_core
	import acc_core_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	output bus_req_t instr_req_o,
	input  bus_rsp_t instr_rsp_i,
	output bus_req_t data_req_o,
	input  bus_rsp_t data_rsp_i,
	output logic     halted_o,
	output logic     fault_o
);

	localparam logic [`ACC_ADDR_W-1:0] INSTR_BYTES = 4;

	typedef enum logic [2:0] {
		FETCH_AP,
		FETCH_DP,
		MEM_AP,
		MEM_DP,
		STOP
	} state_e;

	state_e                 state_q;
	logic [`ACC_ADDR_W-1:0] pc_q;
	logic [`ACC_DATA_W-1:0] acc_q;
	logic                   fault_q;
	acc_instr_u             instr_q;

	acc_instr_u             fetch_word;
	logic                   fetch_stop;
	logic                   op_mem;
	logic [`ACC_ADDR_W-1:0] mem_addr;
	logic [`ACC_DATA_W-1:0] imm_ext;

	// ----------------------------------------------------------
	// Decode

	assign fetch_word = instr_rsp_i.rdata;

	// HALT and any undefined code stop right at fetch
	assign fetch_stop = !(fetch_word.mem.opcode inside {OP_LDI, OP_LD, OP_ADD, OP_ST, OP_JMP});

	assign op_mem = instr_q.mem.opcode inside {OP_LD, OP_ADD, OP_ST};

	// Word address to byte address
	assign mem_addr = {{(`ACC_ADDR_W-30){1'b0}}, instr_q.mem.word_addr, 2'b00};
	assign imm_ext  = {{(`ACC_DATA_W-28){1'b0}}, instr_q.imm.imm};

	// ----------------------------------------------------------
	// Sequencer

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= FETCH_AP;
			pc_q    <= `ACC_RESET_PC;
			acc_q   <= '0;
			fault_q <= 1'b0;
		end else begin
			case (state_q)
				FETCH_AP: begin
					if (instr_rsp_i.aph_ready)
						state_q <= FETCH_DP;
				end
				FETCH_DP: begin
					if (instr_rsp_i.dph_ready) begin
						if (instr_rsp_i.dph_err) begin
							state_q <= STOP;
							fault_q <= 1'b1;
						end else if (fetch_stop) begin
							state_q <= STOP;
						end else begin
							state_q <= MEM_AP;
						end
					end
				end
				// Non-memory ops retire here
				MEM_AP: begin
					if (op_mem) begin
						if (data_rsp_i.aph_ready)
							state_q <= MEM_DP;
					end else if (instr_q.mem.opcode == OP_JMP) begin
						pc_q    <= mem_addr;
						state_q <= FETCH_AP;
					end else begin
						// LDI, the only other code that passes fetch
						acc_q   <= imm_ext;
						pc_q    <= pc_q + INSTR_BYTES;
						state_q <= FETCH_AP;
					end
				end
				MEM_DP: begin
					if (data_rsp_i.dph_ready) begin
						if (data_rsp_i.dph_err) begin
							state_q <= STOP;
							fault_q <= 1'b1;
						end else begin
							case (instr_q.mem.opcode)
								OP_LD:   acc_q <= data_rsp_i.rdata;
								// Wraps at 32 bits
								OP_ADD:  acc_q <= acc_q + data_rsp_i.rdata;
								default: acc_q <= acc_q;
							endcase
							pc_q    <= pc_q + INSTR_BYTES;
							state_q <= FETCH_AP;
						end
					end
				end
				// STOP is terminal until reset
				default: state_q <= STOP;
			endcase
		end
	end

	// Latched instruction word
	always_ff @(posedge clk) begin
		if (state_q == FETCH_DP && instr_rsp_i.dph_ready)
			instr_q <= fetch_word;
	end

	// ----------------------------------------------------------
	// Channel requests

	// Instruction channel never writes, and stays idle while reset is held
	assign instr_req_o.aph_req = rst_n && state_q == FETCH_AP;
	assign instr_req_o.addr    = pc_q;
	assign instr_req_o.write   = 1'b0;
	assign instr_req_o.wdata   = '0;

	// Acc is stable through MEM_AP and MEM_DP
	assign data_req_o.aph_req = state_q == MEM_AP && op_mem;
	assign data_req_o.addr    = mem_addr;
	assign data_req_o.write   = instr_q.mem.opcode == OP_ST;
	assign data_req_o.wdata   = acc_q;

	assign halted_o = state_q == STOP;
	assign fault_o  = fault_q;

	// ----------------------------------------------------------
	// Assertions

	property p_aph_hold(bus_req_t req, bus_rsp_t rsp);
		@(posedge clk) disable iff (!rst_n)
		req.aph_req && !rsp.aph_ready |=> req.aph_req && $stable(req.addr);
	endproperty

	a_instr_aph_hold: assert property (p_aph_hold(instr_req_o, instr_rsp_i));
	a_data_aph_hold:  assert property (p_aph_hold(data_req_o, data_rsp_i));

	// Once stopped, both channels stay quiet
	a_stop_quiet: assert property (@(posedge clk) disable iff (!rst_n)
		halted_o |=> halted_o && !instr_req_o.aph_req && !data_req_o.aph_req);

endmodule

/* design/acc_core_pkg.sv */
// ----------------------------------------------------------
// Accumulator core instruction format and bus channel types
// ----------------------------------------------------------

`include "acc_defines.svh"

package acc_core_pkg;

	// ----------------------------------------------------------
	// Instruction encoding

	// Codes not listed here execute as HALT
	typedef enum logic [3:0] {
		OP_LDI  = 4'h1,
		OP_LD   = 4'h2,
		OP_ADD  = 4'h3,
		OP_ST   = 4'h4,
		OP_JMP  = 4'h5,
		OP_HALT = 4'hf
	} opcode_e;

	// LD, ADD, ST and JMP
	typedef struct packed {
		opcode_e     opcode;
		logic [27:0] word_addr;
	} instr_mem_t;

	// LDI, zero extended
	typedef struct packed {
		opcode_e     opcode;
		logic [27:0] imm;
	} instr_imm_t;

	// Same 32-bit word viewed through either form
	typedef union packed {
		instr_mem_t  mem;
		instr_imm_t  imm;
		logic [31:0] raw;
	} acc_instr_u;

	// ----------------------------------------------------------
	// Core bus channel

	typedef struct packed {
		logic                   aph_req;
		logic [`ACC_ADDR_W-1:0] addr;
		logic                   write;
		logic [`ACC_DATA_W-1:0] wdata;
	} bus_req_t;

	typedef struct packed {
		logic                   aph_ready;
		logic                   dph_ready;
		logic                   dph_err;
		logic [`ACC_DATA_W-1:0] rdata;
	} bus_rsp_t;

endpackage

/* design/acc_cpu_2port.sv */
// ----------------------------------------------------------
// Accumulator CPU with separate AHB-Lite instruction and
// load/store master ports
// ----------------------------------------------------------

`timescale 1ns/100ps

module acc_cpu_2port
	import ahb_pkg::*, acc_core_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	// Instruction fetch port
	output ahb_req_t i_ahb_req_o,
	input  ahb_rsp_t i_ahb_rsp_i,
	// Load/store port
	output ahb_req_t d_ahb_req_o,
	input  ahb_rsp_t d_ahb_rsp_i,
	output logic     halted_o,
	output logic     fault_o
);

	// Core channels
	bus_req_t instr_req;
	bus_rsp_t instr_rsp;
	bus_req_t data_req;
	bus_rsp_t data_rsp;

	// ----------------------------------------------------------
	// Core

	acc_core u_core (
		.clk         (clk),
		.rst_n       (rst_n),
		.instr_req_o (instr_req),
		.instr_rsp_i (instr_rsp),
		.data_req_o  (data_req),
		.data_rsp_i  (data_rsp),
		.halted_o    (halted_o),
		.fault_o     (fault_o)
	);

	// ----------------------------------------------------------
	// Bus ports, no arbitration between them

	ahb_lite_master_port u_iport (
		.clk        (clk),
		.rst_n      (rst_n),
		.core_req_i (instr_req),
		.core_rsp_o (instr_rsp),
		.ahb_req_o  (i_ahb_req_o),
		.ahb_rsp_i  (i_ahb_rsp_i)
	);

	ahb_lite_master_port u_dport (
		.clk        (clk),
		.rst_n      (rst_n),
		.core_req_i (data_req),
		.core_rsp_o (data_rsp),
		.ahb_req_o  (d_ahb_req_o),
		.ahb_rsp_i  (d_ahb_rsp_i)
	);

endmodule

/* design/acc_defines.svh */
// ----------------------------------------------------------
// Accumulator CPU global widths and reset vector
// ----------------------------------------------------------

`ifndef ACC_DEFINES_SVH
`define ACC_DEFINES_SVH

// Byte address width on both AHB-Lite ports
`define ACC_ADDR_W 32

// Word width of the accumulator and of both buses
`define ACC_DATA_W 32

// First fetch address after reset
`define ACC_RESET_PC 32'h0000_0000

`endif

/* design/ahb_lite_master_port.sv */
// ----------------------------------------------------------
// Core bus channel to AHB-Lite master bridge
// ----------------------------------------------------------

`timescale 1ns/100ps
`include "acc_defines.svh"

module ahb_lite_master_port
	import ahb_pkg::*, acc_core_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  bus_req_t core_req_i,
	output bus_rsp_t core_rsp_o,
	output ahb_req_t ahb_req_o,
	input  ahb_rsp_t ahb_rsp_i
);

	logic                   dph_q;
	logic [`ACC_DATA_W-1:0] wdata_q;

	// Data phase in flight, moves only when the bus is ready
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			dph_q <= 1'b0;
		else if (ahb_rsp_i.hready)
			dph_q <= core_req_i.aph_req;
	end

	// Write data captured as the address is accepted
	always_ff @(posedge clk) begin
		if (core_rsp_o.aph_ready)
			wdata_q <= core_req_i.wdata;
	end

	// ----------------------------------------------------------
	// AHB side

	assign ahb_req_o.haddr     = core_req_i.addr;
	assign ahb_req_o.hwrite    = core_req_i.write;
	assign ahb_req_o.htrans    = core_req_i.aph_req ? HTRANS_NONSEQ : HTRANS_IDLE;
	assign ahb_req_o.hsize     = HSIZE_WORD;
	// Single transfer, privileged, unlocked
	assign ahb_req_o.hburst    = 3'b000;
	assign ahb_req_o.hprot     = 4'b0010;
	assign ahb_req_o.hmastlock = 1'b0;
	assign ahb_req_o.hwdata    = wdata_q;

	// ----------------------------------------------------------
	// Core side

	assign core_rsp_o.aph_ready = ahb_rsp_i.hready && core_req_i.aph_req;
	assign core_rsp_o.dph_ready = ahb_rsp_i.hready && dph_q;
	// Only the second error cycle carries hready
	assign core_rsp_o.dph_err   = core_rsp_o.dph_ready && ahb_rsp_i.hresp;
	assign core_rsp_o.rdata     = ahb_rsp_i.hrdata;

	// ----------------------------------------------------------
	// Assertions

	a_hwrite_stall: assert property (@(posedge clk) disable iff (!rst_n)
		ahb_req_o.htrans == HTRANS_NONSEQ && !ahb_rsp_i.hready |=> $stable(ahb_req_o.hwrite));

	// Accepted last cycle, or a stretched data phase carried over
	a_dph_origin: assert property (@(posedge clk) disable iff (!rst_n)
		core_rsp_o.dph_ready |->
			$past(ahb_req_o.htrans == HTRANS_NONSEQ && ahb_rsp_i.hready) ||
			$past(dph_q && !ahb_rsp_i.hready));

endmodule

/* design/ahb_pkg.sv */
// ----------------------------------------------------------
// AHB-Lite transfer encodings and master port structs
// ----------------------------------------------------------

`include "acc_defines.svh"

package ahb_pkg;

	// ----------------------------------------------------------
	// Transfer encodings

	// Only single transfers, so no BUSY or SEQ
	typedef enum logic [1:0] {
		HTRANS_IDLE   = 2'b00,
		HTRANS_NONSEQ = 2'b10
	} htrans_e;

	// Word transfers only
	typedef enum logic [2:0] {
		HSIZE_WORD = 3'b010
	} hsize_e;

	// ----------------------------------------------------------
	// Master port structs

	// Master outputs
	typedef struct packed {
		logic [`ACC_ADDR_W-1:0] haddr;
		logic                   hwrite;
		htrans_e                htrans;
		hsize_e                 hsize;
		logic [2:0]             hburst;
		logic [3:0]             hprot;
		logic                   hmastlock;
		// Lags haddr by one cycle
		logic [`ACC_DATA_W-1:0] hwdata;
	} ahb_req_t;

	// Slave responses
	typedef struct packed {
		logic                   hready;
		logic                   hresp;
		logic [`ACC_DATA_W-1:0] hrdata;
	} ahb_rsp_t;

endpackage

/* sources.f */
+incdir+design
design/ahb_pkg.sv
design/acc_core_pkg.sv
design/acc_core.sv
design/ahb_lite_master_port.sv
design/acc_cpu_2port.sv
tb/ahb_mem_model.sv
tb/tb_acc_cpu_2port.sv

/* tb/ahb_mem_model.sv */
// ----------------------------------------------------------
// AHB-Lite slave memory with LFSR wait states, an error
// region at the top of the space and a log of write transfers
// ----------------------------------------------------------

`timescale 1ns/100ps
`include "acc_defines.svh"

module ahb_mem_model
	import ahb_pkg::*;
#(
	// Top quarter of what the core can address
	parameter logic [`ACC_ADDR_W-1:0] ERR_BASE = 32'h3000_0000
) (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     stall_en_i,
	input  ahb_req_t ahb_req_i,
	output ahb_rsp_t ahb_rsp_o
);

	// 256 words, byte address bits 9:2
	logic [`ACC_DATA_W-1:0] mem [0:255];

	// Write log, address/data pairs in bus order
	logic [`ACC_ADDR_W-1:0] log_addr [0:15];
	logic [`ACC_DATA_W-1:0] log_data [0:15];
	int                     log_cnt;

	logic                   dph_q;
	logic                   write_q;
	logic                   err_q;
	logic                   err2_q;
	logic [1:0]             wait_q;
	logic [`ACC_ADDR_W-1:0] addr_q;
	logic [15:0]            lfsr_q;
	logic [15:0]            lfsr_a;
	logic [15:0]            lfsr_b;
	logic [1:0]             stall_pick;
	logic                   accept;

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		lfsr_step = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	assign lfsr_a = lfsr_step(lfsr_q);
	assign lfsr_b = lfsr_step(lfsr_a);

	// Two fresh bits folded into 0..2 wait cycles
	assign stall_pick = stall_en_i ? ({lfsr_a[0], lfsr_b[0]} % 2'd3) : 2'd0;

	assign accept = ahb_rsp_o.hready && ahb_req_i.htrans == HTRANS_NONSEQ;

	// ----------------------------------------------------------
	// Address and data phase tracking

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dph_q   <= 1'b0;
			write_q <= 1'b0;
			err_q   <= 1'b0;
			err2_q  <= 1'b0;
			wait_q  <= 2'd0;
			addr_q  <= '0;
			lfsr_q  <= 16'd99;
		end else if (ahb_rsp_o.hready) begin
			dph_q   <= accept;
			addr_q  <= ahb_req_i.haddr;
			write_q <= ahb_req_i.hwrite;
			err_q   <= ahb_req_i.haddr >= ERR_BASE;
			err2_q  <= 1'b0;
			wait_q  <= accept ? stall_pick : 2'd0;
			if (accept)
				lfsr_q <= lfsr_b;
		end else if (wait_q != 2'd0) begin
			wait_q <= wait_q - 2'd1;
		end else begin
			// First error cycle done
			err2_q <= 1'b1;
		end
	end

	// Write data lands at the end of the data phase
	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			log_cnt <= 0;
		end else if (ahb_rsp_o.hready && dph_q && write_q && !err_q) begin
			mem[addr_q[9:2]]       <= ahb_req_i.hwdata;
			log_addr[log_cnt[3:0]] <= addr_q;
			log_data[log_cnt[3:0]] <= ahb_req_i.hwdata;
			log_cnt                <= log_cnt + 1;
		end
	end

	// ----------------------------------------------------------
	// Response

	// Error is hresp for two cycles, hready only on the second
	assign ahb_rsp_o.hready = !dph_q || (wait_q == 2'd0 && (!err_q || err2_q));
	assign ahb_rsp_o.hresp  = dph_q && wait_q == 2'd0 && err_q;
	assign ahb_rsp_o.hrdata = (dph_q && !write_q) ? mem[addr_q[9:2]] : '0;

endmodule

/* tb/tb_acc_cpu_2port.sv */
// ----------------------------------------------------------
// Testbench for the two-port accumulator CPU, table of
// programs and expected stores applied in a loop
// ----------------------------------------------------------

`timescale 1ns/100ps
`include "acc_defines.svh"

module tb_acc_cpu_2port
	import ahb_pkg::*, acc_core_pkg::*;
();

	localparam int N_TESTS = 6;
	localparam int PROG_W  = 8;
	localparam int MAX_ST  = 4;
	localparam int TIMEOUT = 2000;

	logic     clk;
	logic     rst_n;
	logic     stall_en;
	ahb_req_t i_req;
	ahb_rsp_t i_rsp;
	ahb_req_t d_req;
	ahb_rsp_t d_rsp;
	logic     halted;
	logic     fault;

	// ----------------------------------------------------------
	// Test table

	string                  t_name    [N_TESTS];
	logic                   t_stall   [N_TESTS];
	logic [31:0]            t_prog    [N_TESTS][PROG_W];
	logic [`ACC_DATA_W-1:0] t_data    [N_TESTS][2];
	int                     t_n_st    [N_TESTS];
	logic [`ACC_ADDR_W-1:0] t_st_addr [N_TESTS][MAX_ST];
	logic [`ACC_DATA_W-1:0] t_st_data [N_TESTS][MAX_ST];
	logic                   t_fault   [N_TESTS];

	// ----------------------------------------------------------
	// DUT and memories

	always #2 clk = ~clk;

	acc_cpu_2port DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_ahb_req_o (i_req),
		.i_ahb_rsp_i (i_rsp),
		.d_ahb_req_o (d_req),
		.d_ahb_rsp_i (d_rsp),
		.halted_o    (halted),
		.fault_o     (fault)
	);

	ahb_mem_model u_imem (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall_en_i (stall_en),
		.ahb_req_i  (i_req),
		.ahb_rsp_o  (i_rsp)
	);

	ahb_mem_model u_dmem (
		.clk        (clk),
		.rst_n      (rst_n),
		.stall_en_i (stall_en),
		.ahb_req_i  (d_req),
		.ahb_rsp_o  (d_rsp)
	);

	// ----------------------------------------------------------
	// Helpers

	function automatic logic [31:0] encode_instr(input opcode_e op, input logic [27:0] field);
		encode_instr = {op, field};
	endfunction

	task automatic abort_run(input string msg);
		$display("TESTS FAILED");
		$display("%s", msg);
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input logic [`ACC_DATA_W-1:0] exp, act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_addr(input string name, input logic [`ACC_ADDR_W-1:0] exp, act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
	endtask

	task automatic check_flag(input string name, input logic exp, act);
		if (act !== exp)
			abort_run($sformatf("mismatch %s: expected %b, actual %b", name, exp, act));
	endtask

	// Single word transfers only, never locked
	task automatic check_xfer_attrs(input string name, input ahb_req_t req, input logic may_write);
		if (req.htrans == HTRANS_NONSEQ) begin
			check_flag({name, " hsize word"}, 1'b1, req.hsize == HSIZE_WORD);
			check_flag({name, " hburst single"}, 1'b1, req.hburst == 3'b000);
			check_flag({name, " hmastlock"}, 1'b0, req.hmastlock);
			if (!may_write)
				check_flag({name, " hwrite"}, 1'b0, req.hwrite);
		end
	endtask

	// Same program, wait states switched on
	task automatic copy_entry(input int dst, input int src, input string name);
		t_name[dst]    = name;
		t_stall[dst]   = 1'b1;
		t_prog[dst]    = t_prog[src];
		t_data[dst]    = t_data[src];
		t_n_st[dst]    = t_n_st[src];
		t_st_addr[dst] = t_st_addr[src];
		t_st_data[dst] = t_st_data[src];
		t_fault[dst]   = t_fault[src];
	endtask

	task automatic build_table();
		for (int k = 0; k < N_TESTS; k++) begin
			t_stall[k]   = 1'b0;
			t_n_st[k]    = 0;
			t_fault[k]   = 1'b0;
			t_data[k][0] = '0;
			t_data[k][1] = '0;
			for (int j = 0; j < PROG_W; j++)
				t_prog[k][j] = encode_instr(OP_HALT, 28'h0);
		end

		// Immediate is zero extended, store goes to word 0x10
		t_name[0]       = "imm_store";
		t_prog[0][0]    = encode_instr(OP_LDI, 28'hFEDCBA9);
		t_prog[0][1]    = encode_instr(OP_ST, 28'h10);
		t_n_st[0]       = 1;
		t_st_addr[0][0] = 32'h40;
		t_st_data[0][0] = {4'h0, 28'hFEDCBA9};

		// Sum wraps at 32 bits
		t_name[1]       = "load_add";
		t_data[1][0]    = 32'hFFFF_FFF0;
		t_data[1][1]    = 32'h0000_0025;
		t_prog[1][0]    = encode_instr(OP_LD, 28'h0);
		t_prog[1][1]    = encode_instr(OP_ST, 28'h3);
		t_prog[1][2]    = encode_instr(OP_ADD, 28'h1);
		t_prog[1][3]    = encode_instr(OP_ST, 28'h2);
		t_n_st[1]       = 2;
		t_st_addr[1][0] = 32'hC;
		t_st_data[1][0] = t_data[1][0];
		t_st_addr[1][1] = 32'h8;
		t_st_data[1][1] = t_data[1][0] + t_data[1][1];

		// Store at word 2 is jumped over
		t_name[2]       = "jump";
		t_prog[2][0]    = encode_instr(OP_LDI, 28'h5);
		t_prog[2][1]    = encode_instr(OP_JMP, 28'h3);
		t_prog[2][2]    = encode_instr(OP_ST, 28'h4);
		t_prog[2][3]    = encode_instr(OP_ST, 28'h5);
		t_n_st[2]       = 1;
		t_st_addr[2][0] = 32'h14;
		t_st_data[2][0] = 32'h5;

		copy_entry(3, 1, "load_add_wait");
		copy_entry(4, 2, "jump_wait");

		// LD from 0x3000_0000 hits the error region
		t_name[5]       = "bus_error";
		t_stall[5]      = 1'b1;
		t_prog[5][0]    = encode_instr(OP_LDI, 28'h7);
		t_prog[5][1]    = encode_instr(OP_ST, 28'h6);
		t_prog[5][2]    = encode_instr(OP_LD, 28'hC00_0000);
		t_prog[5][3]    = encode_instr(OP_ST, 28'h7);
		t_n_st[5]       = 1;
		t_st_addr[5][0] = 32'h18;
		t_st_data[5][0] = 32'h7;
		t_fault[5]      = 1'b1;
	endtask

	// ----------------------------------------------------------
	// One table entry

	task automatic run_test(input int k);
		int n;
		int last;
		@(negedge clk);
		rst_n    = 1'b0;
		stall_en = t_stall[k];
		// Unused words get an address-dependent fill
		for (int a = 0; a < 256; a++) begin
			u_imem.mem[a] = (a < PROG_W) ? t_prog[k][a] : encode_instr(OP_HALT, 28'(a * 4));
			u_dmem.mem[a] = (a < 2) ? t_data[k][a] : (32'hD00D_0000 ^ 32'(a * 4));
		end

		for (int c = 0; c < 8; c++) begin
			@(negedge clk);
			check_flag({t_name[k], " reset i nonseq"}, 1'b0, i_req.htrans == HTRANS_NONSEQ);
			check_flag({t_name[k], " reset d nonseq"}, 1'b0, d_req.htrans == HTRANS_NONSEQ);
			check_flag({t_name[k], " reset halted"}, 1'b0, halted);
			check_flag({t_name[k], " reset fault"}, 1'b0, fault);
		end
		rst_n = 1'b1;

		// First fetch must be up in the cycle after release
		#1;
		check_flag({t_name[k], " first fetch"}, 1'b1, i_req.htrans == HTRANS_NONSEQ);
		check_addr({t_name[k], " first fetch addr"}, `ACC_RESET_PC, i_req.haddr);
		check_flag({t_name[k], " early halted"}, 1'b0, halted);

		n = 0;
		while (!halted) begin
			@(negedge clk);
			check_xfer_attrs({t_name[k], " i port"}, i_req, 1'b0);
			check_xfer_attrs({t_name[k], " d port"}, d_req, 1'b1);
			n++;
			if (n > TIMEOUT)
				abort_run({"timeout: test ", t_name[k], " never raised halted_o"});
		end
		check_flag({t_name[k], " fault"}, t_fault[k], fault);

		// Both ports stay quiet once halted
		for (int c = 0; c < 10; c++) begin
			@(negedge clk);
			check_flag({t_name[k], " late i nonseq"}, 1'b0, i_req.htrans == HTRANS_NONSEQ);
			check_flag({t_name[k], " late d nonseq"}, 1'b0, d_req.htrans == HTRANS_NONSEQ);
			check_flag({t_name[k], " halted held"}, 1'b1, halted);
		end

		if (u_dmem.log_cnt != t_n_st[k])
			abort_run($sformatf("mismatch %s store count: expected %0d, actual %0d",
				t_name[k], t_n_st[k], u_dmem.log_cnt));
		for (int s = 0; s < t_n_st[k]; s++) begin
			check_addr($sformatf("%s store %0d addr", t_name[k], s),
				t_st_addr[k][s], u_dmem.log_addr[s]);
			check_word($sformatf("%s store %0d data", t_name[k], s),
				t_st_data[k][s], u_dmem.log_data[s]);
		end

		// Final stored value visible in memory
		last = t_n_st[k] - 1;
		check_word({t_name[k], " final store"}, t_st_data[k][last],
			u_dmem.mem[t_st_addr[k][last][9:2]]);
	endtask

	initial begin
		clk      = 1'b0;
		rst_n    = 1'b0;
		stall_en = 1'b0;
		build_table();
		for (int k = 0; k < N_TESTS; k++)
			run_test(k);
		$display("TESTS PASSED");
		$finish;
	end

endmodule
